/* logic/lcd_bus_pkg.sv */
/*
 * LCD bus definitions
 * Pin types for the 4-bit HD44780 bus, the command that the sequencer
 * hands to the nibble writer, and the instruction codes used by the
 * init sequence and the refresh loop.
 */
package lcd_bus_pkg;

	typedef logic [3:0] lcd_nibble_t;	// d7..d4
	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] char_pos_t;		// 0..9 within a line

	// one transfer request
	typedef struct packed {
		logic rs;		// 1 = data, 0 = instruction
		logic nibble_only;	// upper nibble only
		lcd_byte_t code;
	} lcd_cmd_t;

	// init nibbles, sent on d7..d4 while the LCD is still in 8-bit mode
	localparam lcd_nibble_t cmd_init_nibble = 4'h3;
	localparam lcd_nibble_t cmd_4bit_nibble = 4'h2;

	localparam lcd_byte_t cmd_function_set = 8'h28;	// 4-bit, 2 lines, 5x8
	localparam lcd_byte_t cmd_display_on = 8'h0f;	// display, cursor, blink
	localparam lcd_byte_t cmd_clear = 8'h01;
	localparam lcd_byte_t cmd_entry_mode = 8'h06;	// increment, no shift
	localparam lcd_byte_t cmd_return_home = 8'h02;
	localparam lcd_byte_t cmd_line2_addr = 8'hc0;	// set DDRAM addr 40h

	// "0x" plus eight hex digits
	localparam int line_chars = 10;

	// hex digit to ascii: value plus base
	localparam lcd_byte_t ascii_digit_base = 8'h30;	// '0'
	localparam lcd_byte_t ascii_letter_base = 8'h37;	// 'A' - 10

endpackage

/* logic/lcd_char_source.sv */
/*
 * LCD character source
 * Takes a snapshot of both input words on snap and turns the current
 * line and position into an ASCII code: "0x" then eight hex digits,
 * most significant nibble first.
 */
`timescale 1ns/1ps

module lcd_char_source
	import lcd_bus_pkg::*;
(
	input logic clk_270k,
	input logic rst,
	input logic snap,
	input logic line_sel,
	input char_pos_t char_pos,
	input logic [31:0] word_a,
	input logic [31:0] word_b,
	output lcd_byte_t char_code
);

	logic [31:0] snap_a;
	logic [31:0] snap_b;
	logic [31:0] sel_word;
	logic [31:0] nib_shift;
	lcd_nibble_t digit;

	// one pass never mixes old and new digits
	always_ff @(posedge clk_270k) begin
		if (rst) begin
			snap_a <= '0;
			snap_b <= '0;
		end else if (snap) begin
			snap_a <= word_a;
			snap_b <= word_b;
		end
	end

	always_comb begin
		sel_word = line_sel ? snap_b : snap_a;
		nib_shift = sel_word << {4'(char_pos - 4'd2), 2'b00};	// pos 2 = top nibble
		digit = nib_shift[31:28];
		case (char_pos)
			4'd0: char_code = "0";
			4'd1: char_code = "x";
			default: begin
				if (digit < 4'd10)
					char_code = ascii_digit_base + {4'h0, digit};
				else
					char_code = ascii_letter_base + {4'h0, digit};
			end
		endcase
	end

endmodule

/* logic/lcd_delay_timer.sv */
/*
 * LCD delay timer
 * Single loadable down-counter for every wait of the sequencer.
 * dly_done pulses exactly N cycles after dly_start, N being the
 * length picked by dly_sel. A new start while busy reloads it.
 */
`timescale 1ns/1ps

module lcd_delay_timer
	import lcd_timing_pkg::*;
#(
	parameter timer_count_t t_power_on = 18'd10800,
	parameter timer_count_t t_4_1ms = 18'd1108,
	parameter timer_count_t t_100us = 18'd27,
	parameter timer_count_t t_37us = 18'd10,
	parameter timer_count_t t_1_52ms = 18'd411,
	parameter timer_count_t t_refresh = 18'd135000
) (
	input logic clk_270k,
	input logic rst,
	input logic dly_start,
	input delay_sel_t dly_sel,
	output logic dly_done
);

	timer_count_t load_len;
	timer_count_t count;
	logic active;

	always_comb begin
		case (dly_sel)
			dly_power_on: load_len = t_power_on;
			dly_4_1ms: load_len = t_4_1ms;
			dly_100us: load_len = t_100us;
			dly_1_52ms: load_len = t_1_52ms;
			dly_refresh: load_len = t_refresh;
			default: load_len = t_37us;
		endcase
	end

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			active <= 1'b0;
			count <= '0;
		end else if (dly_start) begin
			active <= 1'b1;
			count <= load_len - timer_count_t'(1);	// done lands on cycle N
		end else if (active) begin
			if (count == '0)
				active <= 1'b0;
			else
				count <= count - timer_count_t'(1);
		end
	end

	assign dly_done = active && (count == '0);

endmodule

/* logic/lcd_nibble_writer.sv */
/*
 * LCD nibble writer
 * Puts one command on the 4-bit bus: setup cycle, e high for
 * e_high_cycles, one hold cycle. A full byte goes out as upper then
 * lower nibble. wr_done marks the hold cycle of the last nibble.
 */
`timescale 1ns/1ps

module lcd_nibble_writer
	import lcd_bus_pkg::*;
#(
	parameter int unsigned e_high_cycles = 1
) (
	input logic clk_270k,
	input logic rst,
	input logic wr_start,
	input lcd_cmd_t wr_cmd,
	output logic wr_done,
	output logic e,
	output logic rs,
	output lcd_nibble_t data
);

	localparam int e_cnt_w = (e_high_cycles > 1) ? $clog2(e_high_cycles) : 1;

	typedef enum logic [1:0] {st_idle, st_setup, st_strobe, st_hold} wr_state_t;

	wr_state_t state;
	logic low_pending;	// lower nibble still to send
	logic [e_cnt_w-1:0] e_cnt;

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			state <= st_idle;
			low_pending <= 1'b0;
			e_cnt <= '0;
			wr_done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			data <= '0;
		end else begin
			wr_done <= 1'b0;
			case (state)
				st_idle: if (wr_start) begin
					state <= st_setup;
					rs <= wr_cmd.rs;
					data <= wr_cmd.code[7:4];	// upper nibble first
					low_pending <= !wr_cmd.nibble_only;
				end
				st_setup: begin
					state <= st_strobe;
					e <= 1'b1;
					e_cnt <= '0;
				end
				st_strobe: begin
					if (e_cnt == e_cnt_w'(e_high_cycles - 1)) begin
						state <= st_hold;
						e <= 1'b0;
						wr_done <= !low_pending;	// last nibble
					end else begin
						e_cnt <= e_cnt + 1'b1;
					end
				end
				st_hold: begin
					if (low_pending) begin
						state <= st_setup;
						data <= wr_cmd.code[3:0];
						low_pending <= 1'b0;
					end else begin
						state <= st_idle;
						rs <= 1'b0;	// park the bus
						data <= '0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* logic/lcd_sequencer.sv */
/*
 * LCD sequencer
 * Power-on wait and 4-bit init sequence, then the endless refresh
 * loop: line 1, line-2 address, line 2, refresh wait, return home.
 * Every transfer is followed by a timed wait, no busy-flag polling.
 * Also owns the character position and the line select.
 */
`timescale 1ns/1ps

module lcd_sequencer
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;
(
	input logic clk_270k,
	input logic rst,
	input logic wr_done,
	input logic dly_done,
	input lcd_byte_t char_code,
	output logic wr_start,
	output logic dly_start,
	output logic snap,
	output logic line_sel,
	output lcd_cmd_t wr_cmd,
	output delay_sel_t dly_sel,
	output char_pos_t char_pos
);

	typedef enum logic [3:0] {
		s_power, s_init1, s_init2, s_init3, s_4bit,
		s_func, s_disp, s_clear, s_entry,
		s_line1, s_addr2, s_line2, s_home
	} step_t;

	// boot issues the power-on wait, the rest loop per transfer
	typedef enum logic [1:0] {ph_boot, ph_start, ph_write, ph_wait} phase_t;

	step_t step;
	phase_t phase;
	logic last_char;

	assign last_char = (char_pos == char_pos_t'(line_chars - 1));

	assign wr_start = (phase == ph_start);
	assign dly_start = (phase == ph_boot) || ((phase == ph_write) && wr_done);

	// new words only at the start of a pass
	assign snap = (phase == ph_wait) && dly_done && (step == s_entry || step == s_home);

	// wait that follows the current step
	always_comb begin
		case (step)
			s_power: dly_sel = dly_power_on;
			s_init1: dly_sel = dly_4_1ms;
			s_init2: dly_sel = dly_100us;
			s_clear, s_home: dly_sel = dly_1_52ms;
			s_line2: dly_sel = last_char ? dly_refresh : dly_37us;
			default: dly_sel = dly_37us;
		endcase
	end

	always_comb begin
		wr_cmd.rs = 1'b0;
		wr_cmd.nibble_only = 1'b0;
		wr_cmd.code = '0;
		case (step)
			s_init1, s_init2, s_init3: begin
				wr_cmd.nibble_only = 1'b1;
				wr_cmd.code = {cmd_init_nibble, 4'h0};
			end
			s_4bit: begin
				wr_cmd.nibble_only = 1'b1;
				wr_cmd.code = {cmd_4bit_nibble, 4'h0};
			end
			s_func: wr_cmd.code = cmd_function_set;
			s_disp: wr_cmd.code = cmd_display_on;
			s_clear: wr_cmd.code = cmd_clear;
			s_entry: wr_cmd.code = cmd_entry_mode;
			s_addr2: wr_cmd.code = cmd_line2_addr;
			s_home: wr_cmd.code = cmd_return_home;
			s_line1, s_line2: begin
				wr_cmd.rs = 1'b1;	// character write
				wr_cmd.code = char_code;
			end
			default: wr_cmd.code = '0;
		endcase
	end

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			phase <= ph_boot;
			step <= s_power;
			char_pos <= '0;
			line_sel <= 1'b0;
		end else begin
			case (phase)
				ph_boot: phase <= ph_wait;
				ph_start: phase <= ph_write;
				ph_write: if (wr_done) phase <= ph_wait;
				ph_wait: if (dly_done) begin
					phase <= ph_start;
					case (step)
						s_power: step <= s_init1;
						s_init1: step <= s_init2;
						s_init2: step <= s_init3;
						s_init3: step <= s_4bit;
						s_4bit: step <= s_func;
						s_func: step <= s_disp;
						s_disp: step <= s_clear;
						s_clear: step <= s_entry;
						s_entry, s_home: begin	// new pass
							step <= s_line1;
							char_pos <= '0;
							line_sel <= 1'b0;
						end
						s_line1: begin
							if (last_char)
								step <= s_addr2;
							else
								char_pos <= char_pos + 1'b1;
						end
						s_addr2: begin
							step <= s_line2;
							char_pos <= '0;
							line_sel <= 1'b1;
						end
						s_line2: begin
							if (last_char)
								step <= s_home;	// after the refresh wait
							else
								char_pos <= char_pos + 1'b1;
						end
						default: step <= s_power;
					endcase
				end
				default: phase <= ph_boot;
			endcase
		end
	end

endmodule

/* logic/lcd_timing_pkg.sv */
/*
 * LCD timing definitions
 * Wait selection shared by the sequencer and the delay timer, and the
 * counter type that holds one wait length in clk_270k cycles.
 */
package lcd_timing_pkg;

	// one wait length, up to ~0.97 s at 270 kHz
	typedef logic [17:0] timer_count_t;

	// every wait the sequencer can request
	typedef enum logic [2:0] {
		dly_power_on,	// after power up, before the first nibble
		dly_4_1ms,	// after the first init nibble
		dly_100us,	// after the second init nibble
		dly_37us,	// normal instruction / data write
		dly_1_52ms,	// clear and return home
		dly_refresh	// pause between two passes
	} delay_sel_t;

endpackage

/* logic/lcd_top.sv */
/*
 * LCD controller top
 * HD44780 character display on a write-only 4-bit bus. Shows word_a
 * on line 1 and word_b on line 2 as hex, refreshed continuously.
 * Wait lengths are in clk_270k cycles.
 */
`timescale 1ns/1ps

module lcd_top
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;
#(
	parameter timer_count_t t_power_on = 18'd10800,	// 40 ms
	parameter timer_count_t t_4_1ms = 18'd1108,
	parameter timer_count_t t_100us = 18'd27,
	parameter timer_count_t t_37us = 18'd10,
	parameter timer_count_t t_1_52ms = 18'd411,
	parameter timer_count_t t_refresh = 18'd135000,	// 500 ms
	parameter int unsigned e_high_cycles = 1
) (
	input logic clk_270k,
	input logic rst,
	input logic [31:0] word_a,
	input logic [31:0] word_b,
	output logic e,
	output logic rs,
	output lcd_nibble_t data
);

	lcd_cmd_t wr_cmd;
	logic wr_start, wr_done;
	logic dly_start, dly_done;
	delay_sel_t dly_sel;
	logic snap, line_sel;
	char_pos_t char_pos;
	lcd_byte_t char_code;

	lcd_sequencer seq_i (
		.clk_270k, .rst, .wr_done, .dly_done, .char_code,
		.wr_start, .dly_start, .snap, .line_sel, .wr_cmd, .dly_sel, .char_pos
	);

	lcd_nibble_writer #(.e_high_cycles(e_high_cycles)) writer_i (
		.clk_270k, .rst, .wr_start, .wr_cmd, .wr_done, .e, .rs, .data
	);

	lcd_delay_timer #(
		.t_power_on(t_power_on), .t_4_1ms(t_4_1ms), .t_100us(t_100us),
		.t_37us(t_37us), .t_1_52ms(t_1_52ms), .t_refresh(t_refresh)
	) timer_i (
		.clk_270k, .rst, .dly_start, .dly_sel, .dly_done
	);

	lcd_char_source char_i (
		.clk_270k, .rst, .snap, .line_sel, .char_pos, .word_a, .word_b, .char_code
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the LCD controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module lcd_tb -Mdir obj_dir -f sim.f

./obj_dir/Vlcd_tb

/* sim.f */
logic/lcd_timing_pkg.sv
logic/lcd_bus_pkg.sv
logic/lcd_delay_timer.sv
logic/lcd_nibble_writer.sv
logic/lcd_sequencer.sv
logic/lcd_char_source.sv
logic/lcd_top.sv
verif/tb_clock_gen.sv
verif/lcd_checker.sv
verif/lcd_tb.sv

/* verif/lcd_checker.sv */
/*
 * LCD bus checker
 * Concurrent assertions on the pin timing of the 4-bit bus: quiet bus
 * after reset, enable pulse width, setup and hold of rs and data, and
 * the idle time between transfers. Bytes are framed by the short gap
 * between their two nibbles.
 */
`timescale 1ns/1ps

module lcd_checker
	import lcd_bus_pkg::*;
#(
	parameter int t_power_on = 20,
	parameter int t_37us = 4,
	parameter int t_1_52ms = 9,
	parameter int unsigned e_high_cycles = 2
) (
	input logic clk_270k,
	input logic rst,
	input logic e,
	input logic rs,
	input lcd_nibble_t data
);

	int since_rst;		// cycles since reset release, saturating
	int high_run;		// cycles e has been high
	int low_run;		// cycles e has been low
	lcd_nibble_t prev_nib;
	logic long_gap;		// last byte was clear or return home

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			since_rst <= 0;
			high_run <= 0;
			low_run <= 0;
			prev_nib <= '0;
			long_gap <= 1'b0;
		end else begin
			if (since_rst < t_power_on)
				since_rst <= since_rst + 1;
			high_run <= e ? high_run + 1 : 0;
			low_run <= e ? 0 : low_run + 1;
			if (e && low_run != 0) begin	// rising edge of e
				prev_nib <= data;
				if (low_run == 2)	// second nibble of a byte
					long_gap <= !rs && ({prev_nib, data} == 8'h01 || {prev_nib, data} == 8'h02);
				else
					long_gap <= 1'b0;
			end
		end
	end

	a_reset_clears_bus: assert property (@(posedge clk_270k)
		rst |=> !e && !rs && data == '0)
		else $error("bus not cleared by reset");

	a_power_on_quiet: assert property (@(posedge clk_270k) disable iff (rst)
		since_rst < t_power_on |-> !e && !rs && data == '0)
		else $error("bus active before the power-on wait ended");

	a_e_width: assert property (@(posedge clk_270k) disable iff (rst)
		$fell(e) |-> high_run == e_high_cycles)
		else $error("enable pulse has the wrong width");

	// covers the setup cycle before the rise and every high cycle
	a_stable_while_high: assert property (@(posedge clk_270k) disable iff (rst)
		e |-> $stable(data) && $stable(rs))
		else $error("rs or data changed around the enable pulse");

	a_stable_hold: assert property (@(posedge clk_270k) disable iff (rst)
		$fell(e) |-> $stable(data) && $stable(rs))
		else $error("rs or data changed in the hold cycle");

	a_spacing: assert property (@(posedge clk_270k) disable iff (rst)
		$rose(e) |-> low_run == 2 || low_run >= t_37us)
		else $error("transfers too close together");

	a_long_spacing: assert property (@(posedge clk_270k) disable iff (rst)
		$rose(e) && long_gap |-> low_run >= t_1_52ms)
		else $error("short wait after clear or return home");

endmodule

/* verif/lcd_tb.sv */
/*
 * LCD controller testbench
 * Drives random words, decodes the 4-bit bus and checks the init
 * sequence and two full refresh passes against the expected bytes.
 * New words go in halfway through the first pass.
 */
`timescale 1ns/1ps

module lcd_tb
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;
();

	localparam timer_count_t tb_power_on = 18'd20;
	localparam timer_count_t tb_4_1ms = 18'd8;
	localparam timer_count_t tb_100us = 18'd5;
	localparam timer_count_t tb_37us = 18'd4;
	localparam timer_count_t tb_1_52ms = 18'd9;
	localparam timer_count_t tb_refresh = 18'd30;
	localparam int unsigned tb_e_high = 2;
	localparam int rise_limit = 200;	// longest gap is power-on or refresh
	localparam int fall_limit = 20;

	logic clk_270k, rst;
	logic [31:0] word_a, word_b;
	logic e, rs;
	lcd_nibble_t data;
	logic [31:0] exp_a [2];		// words expected per pass
	logic [31:0] exp_b [2];
	int last_wait;			// falling edges spent in the latest wait for e

	tb_clock_gen clk_gen_i (.clk(clk_270k), .rst(rst));

	lcd_top #(
		.t_power_on(tb_power_on), .t_4_1ms(tb_4_1ms), .t_100us(tb_100us),
		.t_37us(tb_37us), .t_1_52ms(tb_1_52ms), .t_refresh(tb_refresh),
		.e_high_cycles(tb_e_high)
	) dut_i (
		.clk_270k(clk_270k), .rst(rst), .word_a(word_a), .word_b(word_b),
		.e(e), .rs(rs), .data(data)
	);

	bind lcd_top lcd_checker #(
		.t_power_on(t_power_on), .t_37us(t_37us), .t_1_52ms(t_1_52ms),
		.e_high_cycles(e_high_cycles)
	) checker_i (
		.clk_270k(clk_270k), .rst(rst), .e(e), .rs(rs), .data(data)
	);

	task automatic stop_with_fail(input string why);
		$display("TB FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got == exp) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// sampled on falling edges, where the bus is stable
	task automatic wait_e_level(input logic level, input int limit);
		int waited;
		waited = 0;
		while (e !== level && waited < limit) begin
			@(negedge clk_270k);
			waited++;
		end
		last_wait = waited;
		if (e !== level)
			stop_with_fail($sformatf("timed out waiting for e to go to %0d", level));
	endtask

	task automatic next_nibble(output logic nib_rs, output lcd_nibble_t nib);
		wait_e_level(1'b0, fall_limit);
		wait_e_level(1'b1, rise_limit);
		nib_rs = rs;
		nib = data;
	endtask

	task automatic expect_nibble(input string what, input logic exp_rs, input lcd_nibble_t exp);
		logic got_rs;
		lcd_nibble_t got;
		next_nibble(got_rs, got);
		check_value($sformatf("rs (%s)", what), 8'(exp_rs), 8'(got_rs));
		check_value($sformatf("data (%s)", what), 8'(exp), 8'(got));
	endtask

	task automatic expect_byte(input string what, input logic exp_rs, input lcd_byte_t exp);
		expect_nibble($sformatf("%s upper", what), exp_rs, exp[7:4]);
		expect_nibble($sformatf("%s lower", what), exp_rs, exp[3:0]);
	endtask

	function automatic lcd_byte_t hex_char(input lcd_nibble_t nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};	// '0'..'9'
		return 8'h41 + {4'h0, nib} - 8'd10;	// 'A'..'F'
	endfunction

	// new words at a falling edge, mid pass
	task automatic change_words();
		word_a = $urandom();
		word_b = $urandom();
		exp_a[1] = word_a;
		exp_b[1] = word_b;
	endtask

	task automatic expect_line(input logic [31:0] word, input string what, input int swap_after);
		lcd_byte_t exp;
		for (int i = 0; i < 10; i++) begin
			if (i == 0)
				exp = 8'h30;	// '0'
			else if (i == 1)
				exp = 8'h78;	// 'x'
			else
				exp = hex_char(word[31 - 4 * (i - 2) -: 4]);
			expect_byte($sformatf("%s char %0d", what, i), 1'b1, exp);
			if (i == swap_after)
				change_words();
		end
	endtask

	initial begin
		int waited;
		void'($urandom(64));
		word_a = $urandom();
		word_b = $urandom();
		exp_a[0] = word_a;
		exp_b[0] = word_b;
		exp_a[1] = word_a;
		exp_b[1] = word_b;
		last_wait = 0;
		waited = 0;
		while (rst !== 1'b0 && waited < fall_limit) begin
			@(negedge clk_270k);
			waited++;
		end
		if (rst !== 1'b0)
			stop_with_fail("reset never released");

		expect_nibble("init 1", 1'b0, 4'h3);
		expect_nibble("init 2", 1'b0, 4'h3);
		expect_nibble("init 3", 1'b0, 4'h3);
		expect_nibble("4-bit switch", 1'b0, 4'h2);
		expect_byte("function set", 1'b0, 8'h28);
		expect_byte("display on", 1'b0, 8'h0f);
		expect_byte("clear", 1'b0, 8'h01);
		expect_byte("entry mode", 1'b0, 8'h06);

		for (int pass = 0; pass < 2; pass++) begin
			expect_line(exp_a[pass], $sformatf("pass %0d line 1", pass), (pass == 0) ? 4 : -1);
			expect_byte("line 2 address", 1'b0, 8'hc0);
			expect_line(exp_b[pass], $sformatf("pass %0d line 2", pass), -1);
			expect_nibble("return home upper", 1'b0, 4'h0);
			// e stays low through the whole refresh wait
			assert (last_wait >= int'(tb_refresh)) else
				stop_with_fail($sformatf("refresh wait too short, e low for %0d cycles",
					last_wait));
			expect_nibble("return home lower", 1'b0, 4'h2);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * Free-running clock, reset held for a fixed number of cycles and
 * released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter realtime period = 20ns,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule
